//--- all.f
design/dbg_cmd_pkg.sv
design/dbg_bus_pkg.sv
design/cdc_toggle_sync.sv
design/dbg_cmd_capture.sv
design/lint_master.sv
design/lint_scratch_mem.sv
design/dbg_mem_bridge_top.sv
tests/dbg_mem_bridge_assert.sv
tests/tb_dbg_mem_bridge.sv

//--- tests/tb_dbg_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_mem_bridge;
	import dbg_cmd_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int MEM_BYTES = MEM_WORDS * 8;
	localparam int TCK_HALF  = 15;  // 30 ns tck
	localparam int RDY_LIMIT = 200; // tck cycles

	logic        clk_i = 1'b0;
	logic        tck_i = 1'b0;
	logic        rstn_i;
	logic        trstn_i;
	logic [63:0] data_i;
	logic [31:0] addr_i;
	dbg_size_t   word_size_i;
	logic        strobe_i;
	logic        rd_wrn_i;
	logic [63:0] data_o;
	logic        rdy_o;
	logic        err_o;

	logic [7:0]  model [MEM_BYTES];
	logic [31:0] words [8];
	int          seed     = 32'h2ce20a7d;
	int          errors   = 0;
	int          timeouts = 0;
	int          accepts  = 0;
	int          grants   = 0;

	dbg_mem_bridge_top #(
		.MEM_WORDS   (MEM_WORDS),
		.SYNC_STAGES (2)
	) i_dut (
		.tck_i       (tck_i),
		.trstn_i     (trstn_i),
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.data_i      (data_i),
		.addr_i      (addr_i),
		.word_size_i (word_size_i),
		.strobe_i    (strobe_i),
		.rd_wrn_i    (rd_wrn_i),
		.data_o      (data_o),
		.rdy_o       (rdy_o),
		.err_o       (err_o)
	);

	always #4 clk_i = ~clk_i;
	always #(TCK_HALF) tck_i = ~tck_i;

	always @(posedge clk_i) begin
		if (i_dut.bus_req.req && i_dut.bus_rsp.gnt) begin
			grants++; // Transfers seen by the memory
		end
	end

	// ##################################################
	// Helpers
	// ##################################################

	function automatic int size_bytes(input logic [3:0] code);
		case (code)
			4'h1: return 1;
			4'h2: return 2;
			4'h4: return 4;
			default: return 8; // Unknown codes mean a full word
		endcase
	endfunction

	task automatic end_run();
		int fails;
		fails = i_dut.i_chk.fails;
		$display("Summary: %0d data errors, %0d assertion failures, %0d timeouts",
			errors, fails, timeouts);
		if (errors == 0 && fails == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic wait_ready();
		int cnt;
		cnt = 0;
		while (!rdy_o) begin
			@(negedge tck_i);
			cnt++;
			if (cnt > RDY_LIMIT) begin
				timeouts++;
				$display("Timeout: rdy_o did not come back within %0d tck cycles", RDY_LIMIT);
				end_run();
			end
		end
	endtask

	// One debug access that holds the strobe for hold extra cycles while busy
	task automatic access(input logic rd, input logic [3:0] code, input logic [31:0] addr,
			input logic [63:0] wdata, input int hold);
		int          nb;
		logic [31:0] base;
		logic [63:0] exp;
		logic        exp_err;
		nb      = size_bytes(code);
		base    = addr & ~(32'(nb) - 32'd1);
		exp_err = base >= MEM_BYTES;
		exp     = '0;
		@(negedge tck_i);
		data_i      = wdata;
		addr_i      = addr;
		word_size_i = code;
		rd_wrn_i    = rd;
		strobe_i    = 1'b1;
		@(negedge tck_i);
		accepts++;
		repeat (hold) @(negedge tck_i);
		strobe_i = 1'b0;
		wait_ready();
		for (int k = 0; k < nb; k++) begin
			if (!exp_err && rd) begin
				exp[8*k +: 8] = model[base + k];
			end
			if (!exp_err && !rd) begin
				model[base + k] = wdata[8*(8 - nb + k) +: 8]; // Data sits at the top
			end
		end
		if (err_o !== exp_err) begin
			errors++;
			$display("ERROR at %0t: err_o %b, expected %b at address %h", $time,
				err_o, exp_err, addr);
		end
		if (rd && data_o !== exp) begin
			errors++;
			$display("ERROR at %0t: read %h size %0d gave %h, expected %h", $time,
				addr, code, data_o, exp);
		end
	endtask

	// ##################################################
	// Stimulus
	// ##################################################

	initial begin
		logic [31:0] a;
		data_i      = '0;
		addr_i      = '0;
		word_size_i = SIZE_8;
		strobe_i    = 1'b0;
		rd_wrn_i    = 1'b1;
		rstn_i      = 1'b0;
		trstn_i     = 1'b0;
		repeat (16) @(posedge clk_i);
		@(negedge clk_i);
		rstn_i = 1'b1;
		@(negedge tck_i);
		trstn_i = 1'b1;
		@(negedge tck_i);
		if (rdy_o !== 1'b1 || err_o !== 1'b0 || data_o !== '0) begin
			errors++;
			$display("ERROR at %0t: after reset rdy_o %b err_o %b data_o %h", $time,
				rdy_o, err_o, data_o);
		end

		// Full words at random low address bits
		for (int i = 0; i < 8; i++) begin
			words[i] = {$random(seed)} % MEM_WORDS;
			a = words[i] * 8 + ({$random(seed)} % 8);
			access(1'b0, SIZE_8, a, {$random(seed), $random(seed)}, i % 3);
		end
		for (int i = 0; i < 8; i++) begin
			access(1'b1, SIZE_8, words[i] * 8, '0, 2);
		end

		// Byte and halfword merges
		for (int l = 0; l < 8; l++) begin
			access(1'b0, SIZE_1, words[0] * 8 + l, {$random(seed), $random(seed)}, 0);
			access(1'b1, SIZE_8, words[0] * 8, '0, 0);
		end
		for (int l = 0; l < 8; l += 2) begin
			access(1'b0, SIZE_2, words[1] * 8 + l, {$random(seed), $random(seed)}, 1);
			access(1'b1, SIZE_8, words[1] * 8, '0, 0);
		end

		// Narrow reads at every offset
		for (int off = 0; off < 8; off++) begin
			access(1'b1, SIZE_1, words[2] * 8 + off, '0, 0);
			access(1'b1, SIZE_2, words[2] * 8 + off, '0, 0);
			access(1'b1, SIZE_4, words[2] * 8 + off, '0, 0);
		end
		access(1'b1, 4'h3, words[3] * 8 + 5, '0, 0);
		access(1'b1, 4'hf, words[3] * 8 + 2, '0, 0);
		access(1'b0, 4'h0, words[3] * 8 + 6, {$random(seed), $random(seed)}, 0);
		access(1'b1, SIZE_8, words[3] * 8, '0, 0);

		// Beyond the end where words[0] would alias without a range check
		access(1'b0, SIZE_8, MEM_BYTES + words[0] * 8, {$random(seed), $random(seed)}, 0);
		access(1'b1, SIZE_4, MEM_BYTES + words[0] * 8, '0, 0);
		access(1'b1, SIZE_8, words[0] * 8, '0, 2);

		repeat (4) @(negedge tck_i);
		if (grants != accepts) begin
			errors++;
			$display("ERROR at %0t: %0d bus transfers for %0d accepted strobes", $time,
				grants, accepts);
		end
		end_run();
	end

endmodule

`default_nettype wire

//--- tests/dbg_mem_bridge_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_mem_bridge_assert (
	input  logic                   tck_i,
	input  logic                   trstn_i,
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   strobe_i,
	input  logic                   rdy_i,
	input  logic                   cmd_tgl_i,
	input  logic                   start_i,
	input  logic                   done_tgl_i,
	input  dbg_bus_pkg::lint_req_t bus_req_i,
	input  dbg_bus_pkg::lint_rsp_t bus_rsp_i
);

	int unsigned fails = 0;

	// ##################################################
	// tck side
	// ##################################################

	a_rdy_fall: assert property (@(posedge tck_i) disable iff (!trstn_i)
		strobe_i && rdy_i |=> !rdy_i)
		else begin
			fails++;
			$error("rdy_o still high one tck edge after an accepted strobe");
		end

	a_cmd_tgl: assert property (@(posedge tck_i) disable iff (!trstn_i)
		$changed(cmd_tgl_i) |-> $past(strobe_i && rdy_i))
		else begin
			fails++;
			$error("Command toggle changed without an accepted strobe");
		end

	// ##################################################
	// clk side, LINT rules
	// ##################################################

	// Fields already valid in the start cycle, request gone after its grant
	a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
		bus_req_i.req |-> $stable({bus_req_i.add, bus_req_i.wdata, bus_req_i.be})
			##1 !bus_req_i.req)
		else begin
			fails++;
			$error("Request fields changed as the request began or request held past grant");
		end

	a_valid_gnt: assert property (@(posedge clk_i) disable iff (!rstn_i)
		bus_rsp_i.r_valid |-> $past(bus_req_i.req && bus_rsp_i.gnt))
		else begin
			fails++;
			$error("Response valid without a granted request one cycle before");
		end

	a_one_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$rose(bus_req_i.req) |-> $past(start_i))
		else begin
			fails++;
			$error("Bus request started without a command start pulse");
		end

	a_done_tgl: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$changed(done_tgl_i) |-> $past(bus_rsp_i.r_valid))
		else begin
			fails++;
			$error("Done toggle changed without a response valid");
		end

endmodule

bind dbg_mem_bridge_top dbg_mem_bridge_assert i_chk (
	.tck_i      (tck_i),
	.trstn_i    (trstn_i),
	.clk_i      (clk_i),
	.rstn_i     (rstn_i),
	.strobe_i   (strobe_i),
	.rdy_i      (rdy_o),
	.cmd_tgl_i  (cmd_tgl),
	.start_i    (start),
	.done_tgl_i (done_tgl),
	.bus_req_i  (bus_req),
	.bus_rsp_i  (bus_rsp)
);

`default_nettype wire

//--- design/dbg_mem_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_mem_bridge_top #(
	parameter int MEM_WORDS   = 256,
	parameter int SYNC_STAGES = 2
) (
	input  logic                   tck_i,
	input  logic                   trstn_i,
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic [63:0]            data_i,
	input  logic [31:0]            addr_i,
	input  dbg_cmd_pkg::dbg_size_t word_size_i,
	input  logic                   strobe_i,
	input  logic                   rd_wrn_i,
	output logic [63:0]            data_o,
	output logic                   rdy_o,
	output logic                   err_o
);
	import dbg_cmd_pkg::*;
	import dbg_bus_pkg::*;

	dbg_cmd_t  cmd;
	dbg_cmd_t  cmd_clk;
	dbg_rsp_t  rsp;
	dbg_rsp_t  rsp_tck;
	logic      cmd_tgl;
	logic      start;
	logic      done_tgl;
	logic      done;
	lint_req_t bus_req;
	lint_rsp_t bus_rsp;

	// ##################################################
	// tck domain
	// ##################################################

	dbg_cmd_capture i_capture (
		.tck_i       (tck_i),
		.trstn_i     (trstn_i),
		.data_i      (data_i),
		.addr_i      (addr_i),
		.word_size_i (word_size_i),
		.strobe_i    (strobe_i),
		.rd_wrn_i    (rd_wrn_i),
		.cmd_o       (cmd),
		.cmd_tgl_o   (cmd_tgl),
		.done_i      (done),
		.rsp_i       (rsp_tck),
		.data_o      (data_o),
		.rdy_o       (rdy_o),
		.err_o       (err_o)
	);

	cdc_toggle_sync #(
		.T           (dbg_rsp_t),
		.SYNC_STAGES (SYNC_STAGES)
	) i_rsp_sync (
		.clk_i     (tck_i),
		.rstn_i    (trstn_i),
		.tgl_i     (done_tgl),
		.payload_i (rsp),
		.pulse_o   (done),
		.payload_o (rsp_tck)
	);

	// ##################################################
	// clk domain
	// ##################################################

	cdc_toggle_sync #(
		.T           (dbg_cmd_t),
		.SYNC_STAGES (SYNC_STAGES)
	) i_cmd_sync (
		.clk_i     (clk_i),
		.rstn_i    (rstn_i),
		.tgl_i     (cmd_tgl),
		.payload_i (cmd),
		.pulse_o   (start),
		.payload_o (cmd_clk)
	);

	lint_master i_master (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.start_i    (start),
		.cmd_i      (cmd_clk),
		.bus_req_o  (bus_req),
		.bus_rsp_i  (bus_rsp),
		.rsp_o      (rsp),
		.done_tgl_o (done_tgl)
	);

	lint_scratch_mem #(
		.MEM_WORDS (MEM_WORDS)
	) i_mem (
		.clk_i     (clk_i),
		.rstn_i    (rstn_i),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp)
	);

endmodule

`default_nettype wire

//--- design/lint_scratch_mem.sv
`timescale 1ns/1ps
`default_nettype none

module lint_scratch_mem #(
	parameter int MEM_WORDS = 256
) (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  dbg_bus_pkg::lint_req_t bus_req_i,
	output dbg_bus_pkg::lint_rsp_t bus_rsp_o
);
	import dbg_bus_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [BUS_DW-1:0] mem [MEM_WORDS];
	logic [IDX_W-1:0]  idx;
	logic              in_range;
	logic              wr_hit;
	logic              rd_hit;
	logic              r_valid_q;
	logic              r_err_q;
	logic [BUS_DW-1:0] r_rdata_q;

	assign idx      = bus_req_i.add[IDX_W+2:3];
	assign in_range = bus_req_i.add < BUS_AW'(MEM_WORDS * 8);
	assign wr_hit   = bus_req_i.req & ~bus_req_i.wen & in_range;
	assign rd_hit   = bus_req_i.req & bus_req_i.wen & in_range;

	always_comb begin
		bus_rsp_o.gnt     = bus_req_i.req; // Never stalls
		bus_rsp_o.r_valid = r_valid_q;
		bus_rsp_o.r_rdata = r_rdata_q;
		bus_rsp_o.r_err   = r_err_q;
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			r_valid_q <= 1'b0;
			r_err_q   <= 1'b0;
		end else begin
			r_valid_q <= bus_req_i.req;
			r_err_q   <= bus_req_i.req & ~in_range;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_hit) begin
			for (int b = 0; b < BUS_BE; b++) begin
				if (bus_req_i.be[b]) mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
			end
		end
		if (bus_req_i.req) begin
			r_rdata_q <= rd_hit ? mem[idx] : '0; // Zero for writes and misses
		end
	end

endmodule

`default_nettype wire

//--- design/lint_master.sv
`timescale 1ns/1ps
`default_nettype none

module lint_master (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   start_i,
	input  dbg_cmd_pkg::dbg_cmd_t  cmd_i,
	output dbg_bus_pkg::lint_req_t bus_req_o,
	input  dbg_bus_pkg::lint_rsp_t bus_rsp_i,
	output dbg_cmd_pkg::dbg_rsp_t  rsp_o,
	output logic                   done_tgl_o
);
	import dbg_bus_pkg::*;

	localparam int LANE_W = $clog2(BUS_BE);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t              state_q;
	logic                req;
	logic [LANE_W-1:0]   lo_lane;
	logic [LANE_W:0]     n_lanes;
	logic [BUS_DW-1:0]   shifted;
	logic [BUS_DW-1:0]   aligned;

	// ##################################################
	// Bus request
	// ##################################################

	assign req = (state_q == ST_REQ);

	always_comb begin
		bus_req_o.req   = req;
		bus_req_o.wen   = ~(req & cmd_i.wr);
		bus_req_o.add   = cmd_i.addr;
		bus_req_o.wdata = cmd_i.wdata;
		bus_req_o.be    = cmd_i.be;
	end

	// ##################################################
	// Read data realignment
	// ##################################################

	always_comb begin
		lo_lane = '0;
		n_lanes = '0;
		for (int i = BUS_BE - 1; i >= 0; i--) begin
			if (cmd_i.be[i]) begin
				lo_lane = LANE_W'(i);
			end
			n_lanes = n_lanes + (LANE_W + 1)'(cmd_i.be[i]);
		end
	end

	assign shifted = bus_rsp_i.r_rdata >> {lo_lane, 3'b000};

	always_comb begin
		for (int i = 0; i < BUS_BE; i++) begin
			aligned[8*i +: 8] = (i < n_lanes) ? shifted[8*i +: 8] : 8'h00;
		end
	end

	// ##################################################
	// FSM
	// ##################################################

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q    <= ST_IDLE;
			done_tgl_o <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: if (start_i) state_q <= ST_REQ;
				ST_REQ:  if (bus_rsp_i.gnt) state_q <= ST_WAIT;
				ST_WAIT: begin
					if (bus_rsp_i.r_valid) begin
						state_q    <= ST_IDLE;
						done_tgl_o <= ~done_tgl_o; // Response back to tck side
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == ST_WAIT && bus_rsp_i.r_valid) begin
			rsp_o.rdata <= aligned;
			rsp_o.err   <= bus_rsp_i.r_err;
		end
	end

endmodule

`default_nettype wire

//--- design/dbg_cmd_capture.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_capture (
	input  logic                   tck_i,
	input  logic                   trstn_i,
	input  logic [63:0]            data_i,
	input  logic [31:0]            addr_i,
	input  dbg_cmd_pkg::dbg_size_t word_size_i,
	input  logic                   strobe_i,
	input  logic                   rd_wrn_i,
	output dbg_cmd_pkg::dbg_cmd_t  cmd_o,
	output logic                   cmd_tgl_o,
	input  logic                   done_i,
	input  dbg_cmd_pkg::dbg_rsp_t  rsp_i,
	output logic [63:0]            data_o,
	output logic                   rdy_o,
	output logic                   err_o
);
	import dbg_cmd_pkg::*;

	logic [7:0]  size_mask;
	logic [3:0]  nbytes;
	logic [2:0]  lane;
	logic [7:0]  be_dec;
	logic [63:0] steered;
	logic        accept;

	// ##################################################
	// Byte enable decode and lane steering
	// ##################################################

	always_comb begin
		case (word_size_i)
			SIZE_1: begin
				size_mask = 8'h01;
				nbytes    = SIZE_1;
				lane      = addr_i[2:0];
			end
			SIZE_2: begin
				size_mask = 8'h03;
				nbytes    = SIZE_2;
				lane      = {addr_i[2:1], 1'b0};
			end
			SIZE_4: begin
				size_mask = 8'h0f;
				nbytes    = SIZE_4;
				lane      = {addr_i[2], 2'b00};
			end
			default: begin // Full word
				size_mask = 8'hff;
				nbytes    = SIZE_8;
				lane      = 3'd0;
			end
		endcase
	end

	assign be_dec = size_mask << lane;

	// Top bytes of data_i down to bit 0, then up to the addressed lane
	assign steered = (data_i >> {4'd8 - nbytes, 3'b000}) << {lane, 3'b000};

	assign accept = strobe_i & rdy_o;

	// ##################################################
	// Command hold and handshake
	// ##################################################

	always_ff @(posedge tck_i) begin
		if (accept) begin
			cmd_o.wr    <= ~rd_wrn_i;
			cmd_o.wdata <= steered;
			cmd_o.be    <= be_dec;
			cmd_o.addr  <= addr_i;
		end
	end

	always_ff @(posedge tck_i or negedge trstn_i) begin
		if (!trstn_i) begin
			cmd_tgl_o <= 1'b0;
			rdy_o     <= 1'b1;
			data_o    <= '0;
			err_o     <= 1'b0;
		end else begin
			if (accept) begin
				cmd_tgl_o <= ~cmd_tgl_o;
				rdy_o     <= 1'b0;
			end else if (done_i) begin
				rdy_o  <= 1'b1;
				data_o <= rsp_i.rdata;
				err_o  <= rsp_i.err;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/cdc_toggle_sync.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_toggle_sync #(
	parameter type T           = logic,
	parameter int  SYNC_STAGES = 2
) (
	input  logic clk_i,
	input  logic rstn_i,
	input  logic tgl_i,
	input  T     payload_i,
	output logic pulse_o,
	output T     payload_o
);

	logic [SYNC_STAGES-1:0] sync_q;
	logic                   tgl_seen_q;
	logic                   load;

	// Toggle about to reach the last stage long after the payload settled
	assign load = sync_q[SYNC_STAGES-1] ^ sync_q[SYNC_STAGES-2];

	assign pulse_o = sync_q[SYNC_STAGES-1] ^ tgl_seen_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			sync_q     <= '0;
			tgl_seen_q <= 1'b0;
		end else begin
			sync_q     <= {sync_q[SYNC_STAGES-2:0], tgl_i};
			tgl_seen_q <= sync_q[SYNC_STAGES-1];
		end
	end

	// Lands on the same edge that raises pulse_o
	always_ff @(posedge clk_i) begin
		if (load) begin
			payload_o <= payload_i;
		end
	end

endmodule

`default_nettype wire

//--- design/dbg_bus_pkg.sv
`default_nettype none

package dbg_bus_pkg;

	// ##################################################
	// Bus geometry
	// ##################################################

	localparam int BUS_DW = 64;
	localparam int BUS_AW = 32;
	localparam int BUS_BE = BUS_DW / 8;

	// ##################################################
	// LINT request and response
	// ##################################################

	typedef struct packed {
		logic              req;
		logic              wen;   // Low for a write
		logic [BUS_AW-1:0] add;
		logic [BUS_DW-1:0] wdata;
		logic [BUS_BE-1:0] be;
	} lint_req_t;

	typedef struct packed {
		logic              gnt;
		logic              r_valid;
		logic [BUS_DW-1:0] r_rdata;
		logic              r_err;
	} lint_rsp_t;

endpackage

`default_nettype wire

//--- design/dbg_cmd_pkg.sv
`default_nettype none

package dbg_cmd_pkg;

	// Access size codes from the debug unit
	typedef logic [3:0] dbg_size_t;

	localparam dbg_size_t SIZE_1 = 4'h1;
	localparam dbg_size_t SIZE_2 = 4'h2;
	localparam dbg_size_t SIZE_4 = 4'h4;
	localparam dbg_size_t SIZE_8 = 4'h8; // Also used for any illegal code

	// One accepted command with its data already on the byte lanes
	typedef struct packed {
		logic        wr;
		logic [63:0] wdata;
		logic [7:0]  be;
		logic [31:0] addr;
	} dbg_cmd_t;

	// Completed access with the read data right aligned
	typedef struct packed {
		logic [63:0] rdata;
		logic        err;
	} dbg_rsp_t;

endpackage

`default_nettype wire
